// ==== source/usb_demo_pkg.sv ====
package usb_demo_pkg;

  // Stream data byte on both bulk endpoints
  localparam int BYTE_W = 8;

  // Board LEDs, active low
  localparam int LED_W = 6;

  // Blink source for the frame counter LED
  //   BLINK_NORMAL  square wave from counter bit BLINK_BIT
  //   BLINK_FAULT   AND of counter bits BLINK_BIT-1 and BLINK_BIT-2,
  //                 a short flash that marks a sticky CRC fault
  typedef enum logic {
    BLINK_NORMAL = 1'b0,
    BLINK_FAULT  = 1'b1
  } blink_mode_e;

  // LED map, low means the condition holds
  //   [5]  frame counter blink
  //   [4]  transfer error latch, qualified by IN ready
  //   [3]  transfer idle
  //   [2]  telemetry present
  //   [1]  unused, held high
  //   [0]  unused, held high

endpackage

// ==== source/loopback_fifo.sv ====
module loopback_fifo #(
  parameter int FIFO_DEPTH = 2048
) (
  input  logic                                  usb_clock,
  input  logic                                  rst_n,
  input  logic                                  usb_reset_i,
  input  logic                                  blk_cycle_i,

  // OUT stream from the core
  input  logic                                  out_valid_i,
  input  logic                                  out_last_i,
  input  logic [usb_demo_pkg::BYTE_W-1:0]       out_data_i,
  output logic                                  out_ready_o,

  // IN stream back to the core
  output logic                                  in_valid_o,
  output logic                                  in_last_o,
  output logic [usb_demo_pkg::BYTE_W-1:0]       in_data_o,
  input  logic                                  in_ready_i,

  output logic [$clog2(FIFO_DEPTH):0]           fill_level_o
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);
  localparam int LVL_W  = ADDR_W + 1;
  localparam int ENT_W  = usb_demo_pkg::BYTE_W + 1;

  // Entry is {last, byte}
  logic [ENT_W-1:0]  mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_q;
  logic [LVL_W-1:0]  level_q;
  logic              in_valid_q;
  logic [ENT_W-1:0]  in_ent_q;

  logic out_take;
  logic in_take;
  logic mem_empty;
  logic load;

  // Both handshakes only count inside a bulk cycle
  assign out_take = out_valid_i && out_ready_o && blk_cycle_i;
  assign in_take  = in_valid_q && in_ready_i && blk_cycle_i;

  // Level includes the output register, so memory holds level minus that
  assign mem_empty = (level_q == LVL_W'(in_valid_q));

  // Refill the output stage when it is empty or being drained
  assign load = !mem_empty && (!in_valid_q || in_take);

  assign out_ready_o  = (level_q < LVL_W'(FIFO_DEPTH));
  assign in_valid_o   = in_valid_q;
  assign in_last_o    = in_ent_q[ENT_W-1];
  assign in_data_o    = in_ent_q[usb_demo_pkg::BYTE_W-1:0];
  assign fill_level_o = level_q;

  // Storage array, no reset
  always_ff @(posedge usb_clock) begin
    if (out_take) begin
      mem[wr_ptr_q] <= {out_last_i, out_data_i};
    end
  end

  // Output data register, payload only
  always_ff @(posedge usb_clock) begin
    if (load) begin
      in_ent_q <= mem[rd_ptr_q];
    end
  end

  always_ff @(posedge usb_clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      in_valid_q <= 1'b0;
    end else if (usb_reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      in_valid_q <= 1'b0;
    end else begin
      if (out_take) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (load) begin
        rd_ptr_q   <= rd_ptr_q + 1'b1;
        in_valid_q <= 1'b1;
      end else if (in_take) begin
        in_valid_q <= 1'b0;
      end
      // Exact count, simultaneous in and out cancel
      case ({out_take, in_take})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

endmodule

// ==== source/bulk_flow_ctrl.sv ====
module bulk_flow_ctrl #(
  parameter int FIFO_DEPTH    = 2048,
  parameter int IN_MIN_LEVEL  = 4,
  parameter int OUT_MAX_LEVEL = 1024
) (
  input  logic                         usb_clock,
  input  logic                         rst_n,
  input  logic                         usb_reset_i,
  input  logic                         configured_i,
  input  logic [$clog2(FIFO_DEPTH):0]  fill_level_i,
  output logic                         blk_in_ready_o,
  output logic                         blk_out_ready_o
);

  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

  logic in_rdy_d;
  logic out_rdy_d;
  logic in_rdy_q;
  logic out_rdy_q;

  // IN only once enough bytes are queued to make a useful packet
  assign in_rdy_d  = configured_i && (fill_level_i > LVL_W'(IN_MIN_LEVEL));
  // OUT while there is room left for a full packet
  assign out_rdy_d = configured_i && (fill_level_i < LVL_W'(OUT_MAX_LEVEL));

  always_ff @(posedge usb_clock or negedge rst_n) begin
    if (!rst_n) begin
      in_rdy_q  <= 1'b0;
      out_rdy_q <= 1'b0;
    end else if (usb_reset_i) begin
      in_rdy_q  <= 1'b0;
      out_rdy_q <= 1'b0;
    end else begin
      in_rdy_q  <= in_rdy_d;
      out_rdy_q <= out_rdy_d;
    end
  end

  assign blk_in_ready_o  = in_rdy_q;
  assign blk_out_ready_o = out_rdy_q;

endmodule

// ==== source/status_leds.sv ====
module status_leds #(
  parameter int BLINK_BIT = 12
) (
  input  logic                             usb_clock,
  input  logic                             rst_n,
  input  logic                             usb_reset_i,
  input  logic                             sof_i,
  input  logic                             crc_err_i,
  input  logic                             xfer_err_i,
  input  logic                             xfer_idle_i,
  input  logic                             has_telemetry_i,
  input  logic                             blk_in_ready_i,
  output logic [usb_demo_pkg::LED_W-1:0]   leds_o
);

  logic [BLINK_BIT:0]        frame_cnt_q;
  logic                      sof_d1_q;
  logic                      sof_d2_q;
  logic                      crc_latch_q;
  logic                      xfer_latch_q;
  logic                      telem_q;
  logic                      sof_rise;
  logic                      blink;
  usb_demo_pkg::blink_mode_e blink_mode;

  // Edge found one cycle after sampling, count bumps on the next edge
  assign sof_rise = sof_d1_q && !sof_d2_q;

  assign blink_mode = crc_latch_q ? usb_demo_pkg::BLINK_FAULT : usb_demo_pkg::BLINK_NORMAL;

  always_comb begin
    case (blink_mode)
      usb_demo_pkg::BLINK_FAULT: begin
        blink = frame_cnt_q[BLINK_BIT-1] & frame_cnt_q[BLINK_BIT-2];
      end
      default: begin
        blink = frame_cnt_q[BLINK_BIT];
      end
    endcase
  end

  always_ff @(posedge usb_clock or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt_q  <= '0;
      sof_d1_q     <= 1'b0;
      sof_d2_q     <= 1'b0;
      crc_latch_q  <= 1'b0;
      xfer_latch_q <= 1'b0;
      telem_q      <= 1'b0;
    end else if (usb_reset_i) begin
      frame_cnt_q  <= '0;
      sof_d1_q     <= 1'b0;
      sof_d2_q     <= 1'b0;
      crc_latch_q  <= 1'b0;
      xfer_latch_q <= 1'b0;
      telem_q      <= 1'b0;
    end else begin
      sof_d1_q <= sof_i;
      sof_d2_q <= sof_d1_q;
      telem_q  <= has_telemetry_i;
      if (sof_rise) begin
        frame_cnt_q <= frame_cnt_q + 1'b1;
      end
      // Sticky until the next reset
      if (crc_err_i) begin
        crc_latch_q <= 1'b1;
      end
      // Only an error seen while IN is offered counts
      if (xfer_err_i && blk_in_ready_i) begin
        xfer_latch_q <= 1'b1;
      end
    end
  end

  // Active low
  assign leds_o = {~blink, ~xfer_latch_q, ~xfer_idle_i, ~telem_q, 2'b11};

endmodule

// ==== source/usb_loopback_top.sv ====
module usb_loopback_top #(
  parameter int FIFO_DEPTH    = 2048,
  parameter int IN_MIN_LEVEL  = 4,
  parameter int OUT_MAX_LEVEL = 1024,
  parameter int BLINK_BIT     = 12
) (
  input  logic                            usb_clock,
  input  logic                            rst_n,

  // Status from the ULPI core
  input  logic                            usb_reset_i,
  input  logic                            configured_i,
  input  logic                            blk_cycle_i,
  input  logic                            sof_i,
  input  logic                            crc_err_i,
  input  logic                            xfer_err_i,
  input  logic                            xfer_idle_i,
  input  logic                            has_telemetry_i,

  // Bulk OUT stream, host to device
  input  logic                            out_valid_i,
  input  logic                            out_last_i,
  input  logic [usb_demo_pkg::BYTE_W-1:0] out_data_i,
  output logic                            out_ready_o,

  // Bulk IN stream, device to host
  output logic                            in_valid_o,
  output logic                            in_last_o,
  output logic [usb_demo_pkg::BYTE_W-1:0] in_data_o,
  input  logic                            in_ready_i,

  // Endpoint flags back to the core
  output logic                            blk_in_ready_o,
  output logic                            blk_out_ready_o,

  output logic [usb_demo_pkg::LED_W-1:0]  leds_o
);

  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

  logic [LVL_W-1:0] fill_level;

  loopback_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) loopback_fifo_inst (
    .usb_clock   (usb_clock),
    .rst_n       (rst_n),
    .usb_reset_i (usb_reset_i),
    .blk_cycle_i (blk_cycle_i),
    .out_valid_i (out_valid_i),
    .out_last_i  (out_last_i),
    .out_data_i  (out_data_i),
    .out_ready_o (out_ready_o),
    .in_valid_o  (in_valid_o),
    .in_last_o   (in_last_o),
    .in_data_o   (in_data_o),
    .in_ready_i  (in_ready_i),
    .fill_level_o(fill_level)
  );

  bulk_flow_ctrl #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .IN_MIN_LEVEL (IN_MIN_LEVEL),
    .OUT_MAX_LEVEL(OUT_MAX_LEVEL)
  ) bulk_flow_ctrl_inst (
    .usb_clock      (usb_clock),
    .rst_n          (rst_n),
    .usb_reset_i    (usb_reset_i),
    .configured_i   (configured_i),
    .fill_level_i   (fill_level),
    .blk_in_ready_o (blk_in_ready_o),
    .blk_out_ready_o(blk_out_ready_o)
  );

  // IN ready also qualifies the transfer error LED
  status_leds #(
    .BLINK_BIT(BLINK_BIT)
  ) status_leds_inst (
    .usb_clock      (usb_clock),
    .rst_n          (rst_n),
    .usb_reset_i    (usb_reset_i),
    .sof_i          (sof_i),
    .crc_err_i      (crc_err_i),
    .xfer_err_i     (xfer_err_i),
    .xfer_idle_i    (xfer_idle_i),
    .has_telemetry_i(has_telemetry_i),
    .blk_in_ready_i (blk_in_ready_o),
    .leds_o         (leds_o)
  );

endmodule

// ==== testbench/clock_gen.sv ====
module clock_gen (
  output logic usb_clock_o
);

  // 20 unit period
  initial begin
    usb_clock_o = 1'b0;
    forever #10 usb_clock_o = ~usb_clock_o;
  end

endmodule

// ==== testbench/usb_loopback_asserts.sv ====
module usb_loopback_asserts #(
  parameter int FIFO_DEPTH = 2048
) (
  input logic                            usb_clock,
  input logic                            rst_n,
  input logic                            usb_reset_i,
  input logic                            blk_cycle_i,
  input logic                            out_valid_i,
  input logic                            in_valid_i,
  input logic                            in_last_i,
  input logic [usb_demo_pkg::BYTE_W-1:0] in_data_i,
  input logic                            in_ready_i,
  input logic [$clog2(FIFO_DEPTH):0]     fill_level_i
);

  // A stalled IN byte holds until it is taken
  in_hold_a: assert property (@(posedge usb_clock) disable iff (!rst_n)
    in_valid_i && !(in_ready_i && blk_cycle_i) && !usb_reset_i
      |=> in_valid_i && $stable(in_data_i) && $stable(in_last_i))
    else $error("IN byte changed or dropped while stalled");

  // Full FIFO never takes a byte
  no_overflow_a: assert property (@(posedge usb_clock) disable iff (!rst_n)
    out_valid_i && blk_cycle_i && fill_level_i == FIFO_DEPTH
      |=> fill_level_i <= FIFO_DEPTH)
    else $error("OUT handshake with the FIFO full");

  rst_idle_a: assert property (@(posedge usb_clock) $rose(rst_n) |-> !in_valid_i)
    else $error("in_valid high after reset release");

  bus_rst_idle_a: assert property (@(posedge usb_clock) disable iff (!rst_n)
    usb_reset_i |=> !in_valid_i)
    else $error("in_valid high after bus reset");

endmodule

bind loopback_fifo usb_loopback_asserts #(
  .FIFO_DEPTH(FIFO_DEPTH)
) usb_loopback_asserts_inst (
  .usb_clock   (usb_clock),
  .rst_n       (rst_n),
  .usb_reset_i (usb_reset_i),
  .blk_cycle_i (blk_cycle_i),
  .out_valid_i (out_valid_i),
  .in_valid_i  (in_valid_o),
  .in_last_i   (in_last_o),
  .in_data_i   (in_data_o),
  .in_ready_i  (in_ready_i),
  .fill_level_i(fill_level_o)
);

// ==== testbench/tb_usb_loopback.sv ====
module tb_usb_loopback;

  localparam int FIFO_DEPTH    = 16;
  localparam int IN_MIN_LEVEL  = 4;
  localparam int OUT_MAX_LEVEL = 12;
  localparam int BLINK_BIT     = 3;
  localparam int BW            = usb_demo_pkg::BYTE_W;

  logic          usb_clock;
  logic          rst_n;
  logic          usb_reset;
  logic          configured;
  logic          blk_cycle;
  logic          sof;
  logic          crc_err;
  logic          xfer_err;
  logic          xfer_idle;
  logic          has_telemetry;
  logic          out_valid;
  logic          out_last;
  logic [BW-1:0] out_data;
  logic          out_ready;
  logic          in_valid;
  logic          in_last;
  logic [BW-1:0] in_data;
  logic          in_ready;
  logic          blk_in_ready;
  logic          blk_out_ready;
  logic [usb_demo_pkg::LED_W-1:0] leds;

  // Scoreboard of {last, data} in flight
  logic [BW:0] exp_q[$];
  logic [BW:0] pend_out_ent;
  logic [BW:0] pend_in_ent;
  logic [31:0] rng_state;
  int          level_m;
  int          n_out;
  int          n_in;
  int          errors;
  int          failed_tests;
  bit          pend_out;
  bit          pend_in;
  bit          expect_vld;
  bit          saw_full;

  clock_gen clock_gen_inst (.usb_clock_o(usb_clock));

  usb_loopback_top #(
    .FIFO_DEPTH(FIFO_DEPTH), .IN_MIN_LEVEL(IN_MIN_LEVEL),
    .OUT_MAX_LEVEL(OUT_MAX_LEVEL), .BLINK_BIT(BLINK_BIT)
  ) usb_loopback_top_inst (
    .usb_clock(usb_clock), .rst_n(rst_n), .usb_reset_i(usb_reset),
    .configured_i(configured), .blk_cycle_i(blk_cycle), .sof_i(sof),
    .crc_err_i(crc_err), .xfer_err_i(xfer_err), .xfer_idle_i(xfer_idle),
    .has_telemetry_i(has_telemetry), .out_valid_i(out_valid), .out_last_i(out_last),
    .out_data_i(out_data), .out_ready_o(out_ready), .in_valid_o(in_valid),
    .in_last_o(in_last), .in_data_o(in_data), .in_ready_i(in_ready),
    .blk_in_ready_o(blk_in_ready), .blk_out_ready_o(blk_out_ready), .leds_o(leds)
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
    errors++;
  endtask

  // Apply the handshakes of the last edge, then check flags and level
  task automatic update_model();
    logic        exp_in_rdy;
    logic        exp_out_rdy;
    logic [BW:0] want;
    exp_in_rdy  = configured && (level_m > IN_MIN_LEVEL);
    exp_out_rdy = configured && (level_m < OUT_MAX_LEVEL);
    if (usb_reset) begin
      exp_in_rdy  = 1'b0;
      exp_out_rdy = 1'b0;
      level_m     = 0;
      expect_vld  = 1'b0;
      exp_q.delete();
    end else begin
      if (expect_vld && !in_valid) begin
        $display("Error at %0t: in_valid_o late for a byte into an empty FIFO", $time);
        errors++;
      end
      expect_vld = pend_out && (level_m == 0);
      if (pend_out) begin
        exp_q.push_back(pend_out_ent);
        level_m++;
        n_out++;
      end
      if (pend_in) begin
        want = exp_q.pop_front();
        if (pend_in_ent !== want)
          report_mismatch("{in_last_o, in_data_o}", 32'(pend_in_ent), 32'(want));
        level_m--;
        n_in++;
      end
    end
    pend_out = 1'b0;
    pend_in  = 1'b0;
    if (blk_in_ready !== exp_in_rdy)
      report_mismatch("blk_in_ready_o", 32'(blk_in_ready), 32'(exp_in_rdy));
    if (blk_out_ready !== exp_out_rdy)
      report_mismatch("blk_out_ready_o", 32'(blk_out_ready), 32'(exp_out_rdy));
    if (out_ready !== (level_m < FIFO_DEPTH))
      report_mismatch("out_ready_o", 32'(out_ready), 32'(level_m < FIFO_DEPTH));
    if (!out_ready) saw_full = 1'b1;
  endtask

  // Sample just after the edge, return at the drive point
  task automatic advance();
    @(posedge usb_clock);
    #1;
    update_model();
    #1;
  endtask

  task automatic drive(input logic ov, input logic ol, input logic [BW-1:0] od,
                       input logic ir, input logic bc);
    out_valid    = ov;
    out_last     = ol;
    out_data     = od;
    in_ready     = ir;
    blk_cycle    = bc;
    // These complete at the coming edge
    pend_out     = ov && out_ready && bc;
    pend_out_ent = {ol, od};
    pend_in      = ir && in_valid && bc;
    pend_in_ent  = {in_last, in_data};
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      drive(1'b0, 1'b0, '0, 1'b0, 1'b1);
      advance();
    end
  endtask

  // Mode 0 always ready, 1 random stalls after a fill phase, 2 never read
  task automatic stream(input int n_send, input int n_recv, input int mode);
    int          sent0;
    int          rcvd0;
    int          idx;
    int          cur_idx;
    int          cycles;
    logic [31:0] r;
    logic [BW-1:0] byte_v;
    logic        ir;
    logic        bc;
    sent0   = n_out;
    rcvd0   = n_in;
    cur_idx = -1;
    cycles  = 0;
    byte_v  = '0;
    while ((n_out - sent0 < n_send || n_in - rcvd0 < n_recv) &&
           cycles < 30 * (n_send + n_recv) + 40) begin
      idx = n_out - sent0;
      if (idx != cur_idx) begin
        r       = next_random();
        byte_v  = r[BW-1:0];
        cur_idx = idx;
      end
      r  = next_random();
      ir = (mode == 0) || (mode == 1 && cycles >= 36 && r[1:0] != 2'b00);
      bc = (mode != 1) || (r[4:2] != 3'b000);
      // Mode 1 also splits the stream into packets of eight
      drive(idx < n_send, (idx == n_send - 1) || (mode == 1 && idx % 8 == 7),
            byte_v, ir, bc);
      advance();
      cycles++;
    end
    if (n_out - sent0 < n_send || n_in - rcvd0 < n_recv) begin
      $display("Timeout at %0t: stream stuck after %0d sent, %0d received", $time,
               n_out - sent0, n_in - rcvd0);
      errors++;
    end
  endtask

  task automatic bus_reset();
    usb_reset = 1'b1;
    idle(1);
    usb_reset = 1'b0;
    idle(1);
  endtask

  task automatic pulse_sof();
    sof = 1'b1;
    idle(1);
    sof = 1'b0;
    idle(3);
  endtask

  task automatic end_test(input string name, input int err0);
    if (errors == err0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - err0);
      failed_tests++;
    end
  endtask

  task automatic test_reset();
    int err0;
    err0 = errors;
    idle(1);
    if (in_valid !== 1'b0) report_mismatch("in_valid_o", 32'(in_valid), 32'h0);
    if (leds !== 6'h3f) report_mismatch("leds_o", 32'(leds), 32'h3f);
    end_test("reset", err0);
  endtask

  task automatic test_loopback();
    int err0;
    err0 = errors;
    stream(10, 10, 0);
    idle(2);
    end_test("loopback", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    err0 = errors;
    saw_full = 1'b0;
    stream(40, 40, 1);
    idle(2);
    if (!saw_full) begin
      $display("Error at %0t: out_ready_o never dropped with 16 bytes held", $time);
      errors++;
    end
    end_test("backpressure", err0);
  endtask

  task automatic test_endpoint_flags();
    int err0;
    err0 = errors;
    bus_reset();
    stream(6, 0, 2);
    idle(2);
    configured = 1'b1;
    idle(2);
    if (blk_in_ready !== 1'b1) report_mismatch("blk_in_ready_o", 32'(blk_in_ready), 32'h1);
    stream(8, 0, 2);
    idle(2);
    if (blk_out_ready !== 1'b0) report_mismatch("blk_out_ready_o", 32'(blk_out_ready), 32'h0);
    stream(0, 14, 0);
    idle(2);
    configured = 1'b0;
    idle(1);
    end_test("endpoint_flags", err0);
  endtask

  task automatic test_leds();
    int                 err0;
    logic [BLINK_BIT:0] cnt;
    logic               exp_led;
    err0 = errors;
    cnt  = '0;
    bus_reset();
    for (int i = 0; i < 8; i++) begin
      pulse_sof();
      cnt     = cnt + 1'b1;
      exp_led = ~cnt[BLINK_BIT];
      if (leds[5] !== exp_led) report_mismatch("leds_o[5]", 32'(leds[5]), 32'(exp_led));
    end
    crc_err = 1'b1;
    idle(1);
    crc_err = 1'b0;
    for (int i = 0; i < 8; i++) begin
      pulse_sof();
      cnt     = cnt + 1'b1;
      exp_led = ~(cnt[BLINK_BIT-1] & cnt[BLINK_BIT-2]);
      if (leds[5] !== exp_led) report_mismatch("leds_o[5]", 32'(leds[5]), 32'(exp_led));
    end
    // IN ready low, error ignored
    bus_reset();
    xfer_err = 1'b1;
    idle(1);
    xfer_err = 1'b0;
    idle(1);
    if (leds[4] !== 1'b1) report_mismatch("leds_o[4]", 32'(leds[4]), 32'h1);
    configured = 1'b1;
    stream(6, 0, 2);
    idle(2);
    xfer_err = 1'b1;
    idle(1);
    xfer_err = 1'b0;
    idle(1);
    if (leds[4] !== 1'b0) report_mismatch("leds_o[4]", 32'(leds[4]), 32'h0);
    bus_reset();
    if (leds[5:4] !== 2'b11) report_mismatch("leds_o[5:4]", 32'(leds[5:4]), 32'h3);
    // Six frames light the LED only in fault mode
    for (int i = 0; i < 6; i++) begin
      pulse_sof();
    end
    if (leds[5] !== 1'b1) report_mismatch("leds_o[5]", 32'(leds[5]), 32'h1);
    // Idle LED follows its input, telemetry LED through one register
    xfer_idle     = 1'b1;
    has_telemetry = 1'b1;
    idle(1);
    if (leds[3:2] !== 2'b00) report_mismatch("leds_o[3:2]", 32'(leds[3:2]), 32'h0);
    xfer_idle     = 1'b0;
    has_telemetry = 1'b0;
    idle(1);
    if (leds[3:2] !== 2'b11) report_mismatch("leds_o[3:2]", 32'(leds[3:2]), 32'h3);
    configured = 1'b0;
    idle(1);
    end_test("leds", err0);
  endtask

  initial begin
    rst_n         = 1'b0;
    usb_reset     = 1'b0;
    configured    = 1'b0;
    blk_cycle     = 1'b0;
    sof           = 1'b0;
    crc_err       = 1'b0;
    xfer_err      = 1'b0;
    xfer_idle     = 1'b0;
    has_telemetry = 1'b0;
    out_valid     = 1'b0;
    out_last      = 1'b0;
    out_data      = '0;
    in_ready      = 1'b0;
    rng_state     = 32'h107a83d8;
    level_m       = 0;
    n_out         = 0;
    n_in          = 0;
    errors        = 0;
    failed_tests  = 0;
    pend_out      = 1'b0;
    pend_in       = 1'b0;
    expect_vld    = 1'b0;
    repeat (16) @(posedge usb_clock);
    #2;
    rst_n = 1'b1;
    test_reset();
    test_loopback();
    test_backpressure();
    test_endpoint_flags();
    test_leds();
    $display("Summary: 5 tests, %0d failed, %0d errors", failed_tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/usb_demo_pkg.sv
source/loopback_fifo.sv
source/bulk_flow_ctrl.sv
source/status_leds.sv
source/usb_loopback_top.sv
testbench/clock_gen.sv
testbench/usb_loopback_asserts.sv
testbench/tb_usb_loopback.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f \
  --top-module tb_usb_loopback -o tb_usb_loopback

status=0
./obj_dir/tb_usb_loopback > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Done: errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
